//--- project.f
logic/lumi_link_pkg.sv
logic/lumi_cmd_pkg.sv
logic/lumi_tx_sizer.sv
logic/lumi_tx_credit.sv
logic/lumi_tx_arbiter.sv
logic/lumi_tx_serializer.sv
logic/lumi_tx.sv
tb/lumi_tx_props.sv
tb/tb_lumi_tx.sv

//--- Makefile
# Verilator build and run of the lumi_tx testbench

all: run

obj_dir/Vtb_lumi_tx: project.f $(wildcard logic/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_lumi_tx -f project.f -o Vtb_lumi_tx

# Pass only when the testbench prints its pass line
run: obj_dir/Vtb_lumi_tx
	./obj_dir/Vtb_lumi_tx | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean

//--- tb/tb_lumi_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lumi_tx
   import lumi_link_pkg::*, lumi_cmd_pkg::*;
;

   localparam int CW  = 32;
   localparam int AW  = 32;
   localparam int DW  = 64;
   localparam int IOW = 64;
   localparam int PW  = CW + 2*AW + DW;
   localparam int CYCLE_LIMIT = 3000;           // Far above the total test length
   localparam logic [31:0] CMD_WRITE = 32'h0000_0303; // Write, size 3, len 0
   localparam logic [31:0] CMD_WRITE_CLIP = 32'h00FF_0303; // 256 beats of 8 bytes

   logic          clk = 1'b0;
   logic          nreset;
   logic          csr_en;
   logic          csr_crdt_en;
   logic [2:0]    csr_iowidth;
   logic          req_valid;
   logic [CW-1:0] req_cmd;
   logic [AW-1:0] req_dstaddr;
   logic [AW-1:0] req_srcaddr;
   logic [DW-1:0] req_data;
   logic          req_ready;
   logic          resp_valid;
   logic [CW-1:0] resp_cmd;
   logic [AW-1:0] resp_dstaddr;
   logic [AW-1:0] resp_srcaddr;
   logic [DW-1:0] resp_data;
   logic          resp_ready;
   crdt_t         rmt_crdt_req;
   crdt_t         rmt_crdt_resp;
   logic [IOW-1:0] phy_txdata;
   logic          phy_txvld;
   logic          phy_txrdy;

   logic [7:0]    exp_q[$];    // Expected byte stream, oldest first
   int            len_q[$];    // Bytes left per pending packet
   bit            take_seen = 0;
   bit            held = 0;
   bit            req_took = 0;
   bit            resp_took = 0;
   bit            take_busy = 0; // Take landed on a consumed word
   bit            stall_en = 0;
   logic [IOW-1:0] held_word = '0;
   int            cycle_cnt = 0;
   logic [15:0]   lfsr_state = 16'd25;
   logic [31:0]   pay_dst;
   logic [31:0]   pay_src;
   logic [63:0]   pay_data;

   lumi_tx #(.CW(CW), .AW(AW), .DW(DW), .IOW(IOW)) uut (.*);

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   //################################################
   // Reporting and random source
   //################################################

   task automatic abort_run();
      $display("Verification failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic report_error(input string what);
      $display("Error at %0t ns: %s", $time, what);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [63:0] observed,
                              input logic [63:0] expected);
      if (observed !== expected)
      begin
         $display("Fail at %0t ns: %s observed %0h expected %0h",
                  $time, name, observed, expected);
         abort_run();
      end
   endtask

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state); // One step per bit
         v = {v[62:0], lfsr_state[0]};
      end
      return v;
   endfunction

   //################################################
   // Reference model
   //################################################

   // Bytes on the wire for one command
   function automatic int model_bytes(input logic [CW-1:0] cmd);
      logic [7:0] op;
      int         data_len;
      op = cmd[OPCODE_LSB +: OPCODE_W];
      data_len = (int'(cmd[LEN_LSB +: LEN_W]) + 1) << cmd[SIZE_LSB +: SIZE_W];
      if (data_len > DW/8)
         data_len = DW/8; // Clip to the data field
      if ((op == OP_INVALID) || (op == OP_LINK))
         return CW/8;
      if ((op == OP_READ) || ((op < 8'h10) && (op != OP_WRITE) &&
                              (op != OP_POSTED) && (op != OP_RESP_READ)))
         return (CW + 2*AW)/8;
      return (CW + 2*AW)/8 + data_len;
   endfunction

   task automatic add_packet(input logic [CW-1:0] cmd, input logic [AW-1:0] dst,
                             input logic [AW-1:0] src, input logic [DW-1:0] data);
      logic [PW-1:0] pkt;
      int            n;
      pkt = {data, src, dst, cmd};   // Byte 0 is the command LSB
      n = model_bytes(cmd);
      for (int i = 0; i < n; i++)
         exp_q.push_back(pkt[8*i +: 8]);
      len_q.push_back(n);
   endtask

   //################################################
   // Cycle step with monitor
   //################################################

   // Sample at negedge, then return 1 ns after the next rising edge
   task automatic tick();
      int         bpw;
      int         nb;
      logic [7:0] exp_byte;
      @(negedge clk);
      bpw = 1 << csr_iowidth;
      if (take_seen)
         check_value("phy_txvld after take", 64'(phy_txvld), 64'd1);
      if (held)
      begin
         check_value("phy_txvld in stall", 64'(phy_txvld), 64'd1);
         check_value("phy_txdata in stall", phy_txdata, held_word);
      end
      if (phy_txvld && (len_q.size() == 0))
         report_error("phy_txvld high with no packet pending");
      take_busy = phy_txvld && phy_txrdy;
      if (phy_txvld && phy_txrdy)
      begin
         nb = (len_q[0] < bpw) ? len_q[0] : bpw; // Tail bytes ignored
         for (int b = 0; b < nb; b++)
         begin
            exp_byte = exp_q.pop_front();
            check_value($sformatf("phy_txdata byte %0d", b),
                        64'(phy_txdata[8*b +: 8]), 64'(exp_byte));
         end
         len_q[0] = len_q[0] - nb;
         if (len_q[0] == 0)
            void'(len_q.pop_front());
      end
      held      = phy_txvld && !phy_txrdy;
      held_word = phy_txdata;
      req_took  = req_valid && req_ready;
      resp_took = resp_valid && resp_ready;
      if (req_took && resp_took)
         report_error("both channels taken in one cycle");
      if (resp_took)
         add_packet(resp_cmd, resp_dstaddr, resp_srcaddr, resp_data);
      else if (req_took)
         add_packet(req_cmd, req_dstaddr, req_srcaddr, req_data);
      take_seen = req_took || resp_took;
      @(posedge clk);
      #1;
      phy_txrdy = stall_en ? 1'(rand_bits(1)) : 1'b1;
   endtask

   task automatic wait_take(input bit from_resp, input int limit);
      int n;
      bit got;
      n = 0;
      got = 0;
      while (!got && (n < limit))
      begin
         tick();
         got = from_resp ? resp_took : req_took;
         n++;
      end
      if (!got)
         report_error("channel never became ready for its packet");
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while ((len_q.size() != 0) && (n < limit))
      begin
         tick();
         n++;
      end
      if (len_q.size() != 0)
         report_error("packet did not finish on the PHY");
   endtask

   task automatic drive_req(input logic [CW-1:0] cmd);
      req_valid   = 1'b1;
      req_cmd     = cmd;
      req_dstaddr = pay_dst;
      req_srcaddr = pay_src;
      req_data    = pay_data;
   endtask

   // One request through the link, idle right after the last model byte
   task automatic send_request(input logic [CW-1:0] cmd);
      drive_req(cmd);
      wait_take(0, 20);
      req_valid = 1'b0;
      wait_drain(200);
      check_value("phy_txvld after last word", 64'(phy_txvld), 64'd0);
   endtask

   //################################################
   // Directed tests
   //################################################

   task automatic write_full_width();
      csr_iowidth = 3'd3;
      send_request(CMD_WRITE);
   endtask

   task automatic write_narrow_stalled();
      csr_iowidth = 3'd1; // 2 bytes per word
      stall_en = 1;
      send_request(CMD_WRITE);
      stall_en = 0;
      csr_iowidth = 3'd3;
   endtask

   task automatic packet_formats();
      send_request({24'h0, OP_LINK});
      send_request({24'h0, OP_READ});
      send_request(CMD_WRITE_CLIP); // 256 beats of 8 bytes
   endtask

   task automatic response_priority();
      resp_valid   = 1'b1;
      resp_cmd     = {8'h00, 8'h00, 8'h02, OP_RESP_READ};
      resp_dstaddr = ~pay_dst;
      resp_srcaddr = ~pay_src;
      resp_data    = ~pay_data;
      drive_req(CMD_WRITE);
      wait_take(1, 20);
      resp_valid = 1'b0;
      wait_take(0, 20);
      check_value("request back to back", 64'(take_busy), 64'd1);
      req_valid = 1'b0;
      wait_drain(200);
   endtask

   task automatic link_disabled();
      csr_en = 1'b0;
      drive_req(CMD_WRITE);
      resp_valid = 1'b1;
      repeat (6)
      begin
         tick();
         check_value("req_ready while disabled", 64'(req_took), 64'd0);
         check_value("resp_ready while disabled", 64'(resp_took), 64'd0);
         check_value("phy_txvld while disabled", 64'(phy_txvld), 64'd0);
      end
      req_valid  = 1'b0;
      resp_valid = 1'b0;
      tick();
      csr_en = 1'b1;
   endtask

   // Sent-line counters are zero from link_disabled
   task automatic credit_gating();
      int lines;
      int lines_clip;
      lines = (model_bytes(CMD_WRITE) + 7) / 8;
      lines_clip = (model_bytes(CMD_WRITE_CLIP) + 7) / 8; // Clipped length only
      csr_crdt_en  = 1'b1;
      rmt_crdt_req = crdt_t'(lines - 1);
      drive_req(CMD_WRITE);
      repeat (5)
      begin
         tick();
         check_value("req_ready short grant", 64'(req_took), 64'd0);
      end
      rmt_crdt_req = crdt_t'(lines);
      wait_take(0, 5);
      req_valid = 1'b0;
      wait_drain(50);
      rmt_crdt_req = crdt_t'(lines + lines_clip - 1); // Cumulative grant
      drive_req(CMD_WRITE_CLIP);
      repeat (5)
      begin
         tick();
         check_value("req_ready second packet", 64'(req_took), 64'd0);
      end
      rmt_crdt_req = crdt_t'(lines + lines_clip);
      wait_take(0, 5);
      req_valid = 1'b0;
      wait_drain(50);
      csr_crdt_en = 1'b0;
   endtask

   initial
   begin
      nreset        = 1'b0;
      csr_en        = 1'b1;
      csr_crdt_en   = 1'b0;
      csr_iowidth   = 3'd3;
      req_valid     = 1'b0;
      req_cmd       = '0;
      req_dstaddr   = '0;
      req_srcaddr   = '0;
      req_data      = '0;
      resp_valid    = 1'b0;
      resp_cmd      = '0;
      resp_dstaddr  = '0;
      resp_srcaddr  = '0;
      resp_data     = '0;
      rmt_crdt_req  = '0;
      rmt_crdt_resp = '0;
      phy_txrdy     = 1'b1;
      pay_dst  = 32'(rand_bits(32));
      pay_src  = 32'(rand_bits(32));
      pay_data = rand_bits(64);
      repeat (3) @(posedge clk);
      #1;
      nreset = 1'b1;
      tick();
      check_value("phy_txvld after reset", 64'(phy_txvld), 64'd0);
      check_value("req_ready after reset", 64'(req_ready), 64'd0);
      write_full_width();
      write_narrow_stalled();
      packet_formats();
      response_priority();
      link_disabled();
      credit_gating();
      repeat (4) tick();   // Idle link, no stray words
      $display("Verification passed");
      $finish;
   end

endmodule : tb_lumi_tx

`default_nettype wire

//--- tb/lumi_tx_props.sv
`timescale 1ns/1ps
`default_nettype none

module lumi_tx_props
#(
   parameter int IOW = 64
)
(
   input wire logic           clk,
   input wire logic           nreset,
   input wire logic           take,
   input wire logic           link_free,
   input wire logic           phy_txvld,
   input wire logic           phy_txrdy,
   input wire logic [IOW-1:0] phy_txdata
);

   //################################################
   // Serializer handshake rules
   //################################################

   // First word only one cycle after a handoff
   vld_after_take: assert property (@(posedge clk) disable iff (!nreset)
      $rose(phy_txvld) |-> $past(take))
      else $error("phy_txvld rose without a take");

   // Back-pressure freezes the word
   hold_on_stall: assert property (@(posedge clk) disable iff (!nreset)
      (phy_txvld && !phy_txrdy) |=> (phy_txvld && $stable(phy_txdata)))
      else $error("PHY word changed while phy_txrdy low");

   free_goes_idle: assert property (@(posedge clk) disable iff (!nreset)
      (link_free && !take) |=> !phy_txvld)    // Free means nothing left after this word
      else $error("phy_txvld still high after link_free without a take");

endmodule : lumi_tx_props

bind lumi_tx_serializer lumi_tx_props #(.IOW(IOW)) u_props
(
   .clk        (clk),
   .nreset     (nreset),
   .take       (take),
   .link_free  (link_free),
   .phy_txvld  (phy_txvld),
   .phy_txrdy  (phy_txrdy),
   .phy_txdata (phy_txdata)
);

`default_nettype wire

//--- logic/lumi_tx.sv
`timescale 1ns/1ps
`default_nettype none

module lumi_tx
   import lumi_link_pkg::*, lumi_cmd_pkg::*;
#(
   parameter int CW  = 32, // Command width
   parameter int AW  = 32, // Address width
   parameter int DW  = 64, // Data width
   parameter int IOW = 64  // PHY word width
)
(
   input  wire logic           clk,
   input  wire logic           nreset,
   input  wire logic           csr_en,
   input  wire logic           csr_crdt_en,
   input  wire logic [2:0]     csr_iowidth,
   // Request channel
   input  wire logic           req_valid,
   input  wire logic [CW-1:0]  req_cmd,
   input  wire logic [AW-1:0]  req_dstaddr,
   input  wire logic [AW-1:0]  req_srcaddr,
   input  wire logic [DW-1:0]  req_data,
   output logic                req_ready,
   // Response channel
   input  wire logic           resp_valid,
   input  wire logic [CW-1:0]  resp_cmd,
   input  wire logic [AW-1:0]  resp_dstaddr,
   input  wire logic [AW-1:0]  resp_srcaddr,
   input  wire logic [DW-1:0]  resp_data,
   output logic                resp_ready,
   // Remote grants
   input  wire crdt_t          rmt_crdt_req,
   input  wire crdt_t          rmt_crdt_resp,
   // PHY side
   output logic      [IOW-1:0] phy_txdata,
   output logic                phy_txvld,
   input  wire logic           phy_txrdy
);

   pkt_fmt_t              req_fmt;
   pkt_fmt_t              resp_fmt;
   logic [LINE_CNT_W-1:0] req_bytes;
   logic [LINE_CNT_W-1:0] resp_bytes;
   crdt_t                 req_lines;
   crdt_t                 resp_lines;
   logic                  req_crdt_ok;
   logic                  resp_crdt_ok;
   logic                  take;
   logic                  take_resp;
   logic                  link_free;
   logic                  word_sent;
   pkt_class_t            word_class;

   //################################################
   // Per channel sizing and credit
   //################################################

   lumi_tx_sizer #(.CW(CW), .AW(AW), .DW(DW)) u_size_req
   (
      .cmd         (req_cmd),
      .csr_iowidth (csr_iowidth),
      .fmt         (req_fmt),
      .pkt_bytes   (req_bytes),
      .pkt_lines   (req_lines)
   );

   lumi_tx_sizer #(.CW(CW), .AW(AW), .DW(DW)) u_size_resp
   (
      .cmd         (resp_cmd),
      .csr_iowidth (csr_iowidth),
      .fmt         (resp_fmt),
      .pkt_bytes   (resp_bytes),
      .pkt_lines   (resp_lines)
   );

   lumi_tx_credit #(.THIS_CLASS(CLASS_REQ)) u_crdt_req
   (
      .clk         (clk),
      .nreset      (nreset),
      .csr_en      (csr_en),
      .csr_crdt_en (csr_crdt_en),
      .rmt_crdt    (rmt_crdt_req),
      .pkt_lines   (req_lines),
      .word_sent   (word_sent),
      .word_class  (word_class),
      .crdt_ok     (req_crdt_ok)
   );

   lumi_tx_credit #(.THIS_CLASS(CLASS_RESP)) u_crdt_resp
   (
      .clk         (clk),
      .nreset      (nreset),
      .csr_en      (csr_en),
      .csr_crdt_en (csr_crdt_en),
      .rmt_crdt    (rmt_crdt_resp),
      .pkt_lines   (resp_lines),
      .word_sent   (word_sent),
      .word_class  (word_class),
      .crdt_ok     (resp_crdt_ok)
   );

   //################################################
   // Arbitration and serialization
   //################################################

   lumi_tx_arbiter u_arbiter
   (
      .csr_en       (csr_en),
      .req_valid    (req_valid),
      .resp_valid   (resp_valid),
      .req_crdt_ok  (req_crdt_ok),
      .resp_crdt_ok (resp_crdt_ok),
      .link_free    (link_free),
      .req_ready    (req_ready),
      .resp_ready   (resp_ready),
      .take         (take),
      .take_resp    (take_resp)
   );

   lumi_tx_serializer #(.CW(CW), .AW(AW), .DW(DW), .IOW(IOW)) u_serializer
   (
      .clk          (clk),
      .nreset       (nreset),
      .csr_iowidth  (csr_iowidth),
      .take         (take),
      .take_resp    (take_resp),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .req_fmt      (req_fmt),
      .resp_fmt     (resp_fmt),
      .req_bytes    (req_bytes),
      .resp_bytes   (resp_bytes),
      .phy_txrdy    (phy_txrdy),
      .phy_txdata   (phy_txdata),
      .phy_txvld    (phy_txvld),
      .link_free    (link_free),
      .word_sent    (word_sent),
      .word_class   (word_class)
   );

endmodule : lumi_tx

`default_nettype wire

//--- logic/lumi_tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module lumi_tx_serializer
   import lumi_link_pkg::*, lumi_cmd_pkg::*;
#(
   parameter int CW  = 32, // Command width
   parameter int AW  = 32, // Address width
   parameter int DW  = 64, // Data width
   parameter int IOW = 64  // PHY word width
)
(
   input  wire logic                  clk,
   input  wire logic                  nreset,
   input  wire logic [2:0]            csr_iowidth,
   input  wire logic                  take,
   input  wire logic                  take_resp,
   input  wire logic [CW-1:0]         req_cmd,
   input  wire logic [AW-1:0]         req_dstaddr,
   input  wire logic [AW-1:0]         req_srcaddr,
   input  wire logic [DW-1:0]         req_data,
   input  wire logic [CW-1:0]         resp_cmd,
   input  wire logic [AW-1:0]         resp_dstaddr,
   input  wire logic [AW-1:0]         resp_srcaddr,
   input  wire logic [DW-1:0]         resp_data,
   input  wire pkt_fmt_t              req_fmt,
   input  wire pkt_fmt_t              resp_fmt,
   input  wire logic [LINE_CNT_W-1:0] req_bytes,
   input  wire logic [LINE_CNT_W-1:0] resp_bytes,
   input  wire logic                  phy_txrdy,
   output logic      [IOW-1:0]        phy_txdata,
   output logic                       phy_txvld,
   output logic                       link_free,
   output logic                       word_sent,
   output pkt_class_t                 word_class
);

   localparam int PW  = CW + 2*AW + DW;  // Packet bits
   localparam int PB  = PW / 8;          // Packet bytes
   localparam int SHW = $clog2(IOW) + 1; // Holds IOW itself

   logic [PW-1:0]         shreg;    // Payload, byte 0 goes out first
   logic [PB-1:0]         mask;     // One bit per byte still to send
   logic [PB-1:0]         mask_next;
   logic [PW-1:0]         load_data;
   logic [PB-1:0]         load_mask;
   logic [CW-1:0]         sel_cmd;
   logic [AW-1:0]         sel_dstaddr;
   logic [AW-1:0]         sel_srcaddr;
   logic [DW-1:0]         sel_data;
   pkt_fmt_t              sel_fmt;
   logic [LINE_CNT_W-1:0] sel_bytes;
   logic [SHW-1:0]        byte_rate;
   logic [SHW-1:0]        bit_rate;
   logic                  last_word;

   //################################################
   // Winner select and load value
   //################################################

   assign sel_cmd     = take_resp ? resp_cmd     : req_cmd;
   assign sel_dstaddr = take_resp ? resp_dstaddr : req_dstaddr;
   assign sel_srcaddr = take_resp ? resp_srcaddr : req_srcaddr;
   assign sel_data    = take_resp ? resp_data    : req_data;
   assign sel_fmt     = take_resp ? resp_fmt     : req_fmt;
   assign sel_bytes   = take_resp ? resp_bytes   : req_bytes;

   // Unsent fields loaded as zero, keeps the tail of the last word clean
   always_comb
   begin
      case (sel_fmt)
         FMT_CMD_ONLY:    load_data = {{(DW+2*AW){1'b0}}, sel_cmd};
         FMT_HEADER_ONLY: load_data = {{DW{1'b0}}, sel_srcaddr, sel_dstaddr, sel_cmd};
         default:         load_data = {sel_data, sel_srcaddr, sel_dstaddr, sel_cmd};
      endcase
   end

   assign load_mask = ~({PB{1'b1}} << sel_bytes); // Low sel_bytes bits set

   //################################################
   // Shift control
   //################################################

   assign byte_rate = SHW'(1) << csr_iowidth; // Bytes per PHY word
   assign bit_rate  = byte_rate << 3;

   assign mask_next = mask >> byte_rate;
   assign last_word = ~|mask_next;           // Nothing left after this word

   assign phy_txvld = |mask;
   assign word_sent = phy_txvld & phy_txrdy;
   assign link_free = ~phy_txvld | (last_word & phy_txrdy);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         mask       <= '0;
         word_class <= CLASS_NONE;
      end
      else if (take)
      begin
         mask       <= load_mask;
         word_class <= take_resp ? CLASS_RESP : CLASS_REQ;
      end
      else if (word_sent)
      begin
         mask <= mask_next;
         if (last_word)
            word_class <= CLASS_NONE; // Drained
      end
   end

   // Payload only, validity lives in the mask
   always_ff @(posedge clk)
   begin
      if (take)
         shreg <= load_data;
      else if (word_sent)
         shreg <= shreg >> bit_rate;
   end

   assign phy_txdata = shreg[IOW-1:0]; // Upper bytes unused at narrow widths

endmodule : lumi_tx_serializer

`default_nettype wire

//--- logic/lumi_tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module lumi_tx_arbiter
(
   input  wire logic csr_en,
   input  wire logic req_valid,
   input  wire logic resp_valid,
   input  wire logic req_crdt_ok,
   input  wire logic resp_crdt_ok,
   input  wire logic link_free,  // Serializer can load this cycle
   output logic      req_ready,
   output logic      resp_ready,
   output logic      take,       // Packet handoff this cycle
   output logic      take_resp   // Handoff comes from the response channel
);

   logic req_elig;
   logic resp_elig;

   //################################################
   // Eligibility
   //################################################

   // Valid, enough remote credit and room in the serializer
   assign req_elig  = csr_en & req_valid  & req_crdt_ok  & link_free;
   assign resp_elig = csr_en & resp_valid & resp_crdt_ok & link_free;

   //################################################
   // Fixed priority, responses first
   //################################################

   // Responses can unblock the far side, so they never wait on requests
   assign resp_ready = resp_elig;
   assign req_ready  = req_elig & ~resp_elig; // Loses to any eligible response

   assign take      = req_elig | resp_elig;
   assign take_resp = resp_elig;

endmodule : lumi_tx_arbiter

`default_nettype wire

//--- logic/lumi_tx_credit.sv
`timescale 1ns/1ps
`default_nettype none

module lumi_tx_credit
   import lumi_link_pkg::*;
#(
   parameter pkt_class_t THIS_CLASS = CLASS_REQ // Channel being tracked
)
(
   input  wire logic       clk,
   input  wire logic       nreset,
   input  wire logic       csr_en,
   input  wire logic       csr_crdt_en, // 0 = infinite credit
   input  wire crdt_t      rmt_crdt,    // Cumulative remote grant
   input  wire crdt_t      pkt_lines,   // Lines needed by the head packet
   input  wire logic       word_sent,
   input  wire pkt_class_t word_class,
   output logic            crdt_ok
);

   crdt_t sent_lines; // Lines consumed so far on this channel
   crdt_t crdt_avail;
   logic  line_used;

   // A word of our class leaves this cycle
   assign line_used = word_sent & (word_class == THIS_CLASS);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         sent_lines <= '0;
      else if (!csr_en)
         sent_lines <= '0;              // Link off, start over
      else if (line_used)
         sent_lines <= sent_lines + crdt_t'(1);
   end

   // Current word counted already, so a take on the last word cannot overrun
   assign crdt_avail = rmt_crdt - sent_lines - crdt_t'(line_used);

   assign crdt_ok = !csr_crdt_en || (crdt_avail >= pkt_lines);

endmodule : lumi_tx_credit

`default_nettype wire

//--- logic/lumi_tx_sizer.sv
`timescale 1ns/1ps
`default_nettype none

module lumi_tx_sizer
   import lumi_link_pkg::*, lumi_cmd_pkg::*;
#(
   parameter int CW = 32, // Command width
   parameter int AW = 32, // Address width
   parameter int DW = 64  // Data width
)
(
   input  wire logic [CW-1:0]         cmd,
   input  wire logic [2:0]            csr_iowidth, // log2 bytes per PHY word
   output pkt_fmt_t                   fmt,
   output logic      [LINE_CNT_W-1:0] pkt_bytes,
   output crdt_t                      pkt_lines
);

   localparam int RAW_W = LEN_W + 9; // (len+1) << size, worst case 256*128

   logic [OPCODE_W-1:0]   opcode;
   logic [SIZE_W-1:0]     size;
   logic [LEN_W-1:0]      len;
   logic [RAW_W-1:0]      raw_data;
   logic [LINE_CNT_W-1:0] data_bytes;
   logic [LINE_CNT_W-1:0] whole_lines;
   logic [LINE_CNT_W-1:0] rem_bytes;

   assign opcode = cmd[OPCODE_LSB +: OPCODE_W];
   assign size   = cmd[SIZE_LSB +: SIZE_W];
   assign len    = cmd[LEN_LSB +: LEN_W];

   // Requested data, clipped to the data field
   assign raw_data   = (RAW_W'(len) + RAW_W'(1)) << size;
   assign data_bytes = (raw_data > RAW_W'(DW/8)) ? LINE_CNT_W'(DW/8)
                                                 : raw_data[LINE_CNT_W-1:0];

   // Opcode classification
   always_comb
   begin
      if ((opcode == OP_INVALID) || (opcode == OP_LINK))
         fmt = FMT_CMD_ONLY;
      else if ((opcode == OP_WRITE) || (opcode == OP_POSTED) || (opcode == OP_RESP_READ))
         fmt = FMT_FULL;
      else if ((opcode == OP_READ) || (opcode == OP_RESP_WRITE) ||
               (opcode < OP_NODATA_LIMIT))
         fmt = FMT_HEADER_ONLY; // Write response carries no data either
      else
         fmt = FMT_FULL;        // Unknown upper opcodes, send everything
   end

   always_comb
   begin
      case (fmt)
         FMT_CMD_ONLY:    pkt_bytes = LINE_CNT_W'(CW/8);
         FMT_HEADER_ONLY: pkt_bytes = LINE_CNT_W'((CW+2*AW)/8);
         default:         pkt_bytes = LINE_CNT_W'((CW+2*AW)/8) + data_bytes;
      endcase
   end

   // Lines = ceil(bytes / 2^iowidth)
   assign whole_lines = pkt_bytes >> csr_iowidth;
   assign rem_bytes   = pkt_bytes & ~({LINE_CNT_W{1'b1}} << csr_iowidth);
   assign pkt_lines   = crdt_t'(whole_lines) + crdt_t'(|rem_bytes);

endmodule : lumi_tx_sizer

`default_nettype wire

//--- logic/lumi_cmd_pkg.sv
`default_nettype none

package lumi_cmd_pkg;

   //################################################
   // Command word fields
   //################################################

   localparam int OPCODE_LSB = 0;  // Opcode in bits 7:0
   localparam int OPCODE_W   = 8;
   localparam int SIZE_LSB   = 8;  // log2 bytes per beat, bits 10:8
   localparam int SIZE_W     = 3;
   localparam int LEN_LSB    = 16; // Beats minus one, bits 23:16
   localparam int LEN_W      = 8;

   //################################################
   // Opcodes
   //################################################

   localparam logic [OPCODE_W-1:0] OP_INVALID    = 8'h00;
   localparam logic [OPCODE_W-1:0] OP_READ       = 8'h01;
   localparam logic [OPCODE_W-1:0] OP_RESP_READ  = 8'h02;
   localparam logic [OPCODE_W-1:0] OP_WRITE      = 8'h03;
   localparam logic [OPCODE_W-1:0] OP_RESP_WRITE = 8'h04;
   localparam logic [OPCODE_W-1:0] OP_POSTED     = 8'h05;
   localparam logic [OPCODE_W-1:0] OP_LINK       = 8'h2F;

   // Opcodes below this with no data field of their own
   localparam logic [OPCODE_W-1:0] OP_NODATA_LIMIT = 8'h10;

   // Which fields of a packet go on the wire
   typedef enum logic [1:0]
   {
      FMT_CMD_ONLY    = 2'd0, // Command word only
      FMT_HEADER_ONLY = 2'd1, // Command plus both addresses
      FMT_FULL        = 2'd2  // Header plus data bytes
   } pkt_fmt_t;

endpackage : lumi_cmd_pkg

`default_nettype wire

//--- logic/lumi_link_pkg.sv
`default_nettype none

package lumi_link_pkg;

   //################################################
   // Link level widths
   //################################################

   // Byte and line counts, sized for the largest packet at 1 byte per word
   localparam int LINE_CNT_W = 12;

   // Cumulative grant and sent-line counts, wrap modulo 2^16
   typedef logic [15:0] crdt_t;

   //################################################
   // Packet class
   //################################################

   // Owner of the packet held in the serializer
   typedef enum logic [1:0]
   {
      CLASS_NONE = 2'd0, // Serializer empty
      CLASS_REQ  = 2'd1, // Request channel
      CLASS_RESP = 2'd2  // Response channel
   } pkt_class_t;

endpackage : lumi_link_pkg

`default_nettype wire
